// ==== sim.f ====
source/cnn_pkg.sv
source/conv_layer.sv
source/global_max_pool.sv
source/class_argmax.sv
source/cnn_classifier.sv
testbench/tb_cnn_classifier.sv

// ==== Makefile ====
# Verilator flow for the CNN classifier

VERILATOR ?= verilator
FILELIST ?= sim.f
TOP ?= tb_cnn_classifier
RTL_TOP ?= cnn_classifier
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --timing
BUILD_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint lint_rtl build sim clean

all: sim

# Whole project including the testbench
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Design only
lint_rtl:
	$(VERILATOR) --lint-only $(LINT_FLAGS) \
		source/cnn_pkg.sv source/conv_layer.sv source/global_max_pool.sv \
		source/class_argmax.sv source/cnn_classifier.sv --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# Status follows the pass line in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_cnn_classifier.sv ====
`timescale 1ns/1ps

module tb_cnn_classifier;

    // Network shape, same as the DUT defaults
    localparam int IN_SIZE = 8;
    localparam int FILTERS_1 = 4;
    localparam int NUM_CLASSES = 4;
    localparam int KER_SIZE = 3;
    localparam int STRIDE_1 = 1;
    localparam int STRIDE_2 = 2;
    localparam int PADDING = 1;
    localparam int OUT_SIZE_1 = ((IN_SIZE - KER_SIZE + 2 * PADDING) / STRIDE_1) + 1;
    localparam int OUT_SIZE_2 = ((OUT_SIZE_1 - KER_SIZE + 2 * PADDING) / STRIDE_2) + 1;

    // Run length
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY = 4;
    localparam int NUM_RANDOM = 200;
    localparam int TOTAL_IMAGES = 3 + NUM_RANDOM;
    localparam int WATCHDOG_NS = (RESET_CYCLES + TOTAL_IMAGES + 20) * CLK_PERIOD * 2;

    // Largest positive Q8.8 value
    localparam longint PIXEL_MAX = 32767;

    typedef cnn_pkg::pixel_t [IN_SIZE*IN_SIZE-1:0] image_t;

    logic clk = 1'b0;
    logic rst;
    image_t image;
    cnn_pkg::result_t result;

    // Posedge count, stable at every falling edge
    int cycle = 0;
    integer seed = 27;

    // Pending expectations, one entry per image, oldest first
    cnn_pkg::result_t exp_q[$];
    string name_q[$];
    int due_q[$];

    int check_count = 0;
    int fail_count = 0;
    int mark_checks;
    int mark_fails;
    int tests_passed = 0;
    int tests_failed = 0;

    cnn_classifier #(
        .IN_SIZE(IN_SIZE),
        .FILTERS_1(FILTERS_1),
        .NUM_CLASSES(NUM_CLASSES),
        .KER_SIZE(KER_SIZE),
        .STRIDE_1(STRIDE_1),
        .STRIDE_2(STRIDE_2),
        .PADDING(PADDING)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .image(image),
        .result(result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Floor shift back to Q8.8, ReLU, then clip at the top
    function automatic longint rescale_activation(input longint acc);
        longint scaled;
        scaled = acc >>> cnn_pkg::FRACTIONAL_BITS;
        if (scaled < 0) begin
            scaled = 0;
        end else if (scaled > PIXEL_MAX) begin
            scaled = PIXEL_MAX;
        end
        return scaled;
    endfunction

    // Expected class and score for one image
    function automatic cnn_pkg::result_t reference_classify(input image_t img);
        longint fm1 [FILTERS_1][OUT_SIZE_1][OUT_SIZE_1];
        longint fm2 [NUM_CLASSES][OUT_SIZE_2][OUT_SIZE_2];
        longint acc;
        longint score;
        longint best_score;
        int iy;
        int ix;
        int best_class;
        cnn_pkg::result_t res;
        // Layer 1, single input channel
        for (int f = 0; f < FILTERS_1; f++) begin
            for (int oy = 0; oy < OUT_SIZE_1; oy++) begin
                for (int ox = 0; ox < OUT_SIZE_1; ox++) begin
                    acc = longint'(cnn_pkg::bias_value(1, f)) <<< cnn_pkg::FRACTIONAL_BITS;
                    for (int r = 0; r < KER_SIZE; r++) begin
                        for (int k = 0; k < KER_SIZE; k++) begin
                            iy = STRIDE_1 * oy - PADDING + r;
                            ix = STRIDE_1 * ox - PADDING + k;
                            // Zero padding outside the image
                            if (iy >= 0 && iy < IN_SIZE && ix >= 0 && ix < IN_SIZE) begin
                                acc += longint'(cnn_pkg::weight_value(1, f, 0, r, k)) *
                                       longint'(img[iy*IN_SIZE + ix]);
                            end
                        end
                    end
                    fm1[f][oy][ox] = rescale_activation(acc);
                end
            end
        end
        // Layer 2, one map per class
        for (int f = 0; f < NUM_CLASSES; f++) begin
            for (int oy = 0; oy < OUT_SIZE_2; oy++) begin
                for (int ox = 0; ox < OUT_SIZE_2; ox++) begin
                    acc = longint'(cnn_pkg::bias_value(2, f)) <<< cnn_pkg::FRACTIONAL_BITS;
                    for (int c = 0; c < FILTERS_1; c++) begin
                        for (int r = 0; r < KER_SIZE; r++) begin
                            for (int k = 0; k < KER_SIZE; k++) begin
                                iy = STRIDE_2 * oy - PADDING + r;
                                ix = STRIDE_2 * ox - PADDING + k;
                                if (iy >= 0 && iy < OUT_SIZE_1 && ix >= 0 && ix < OUT_SIZE_1)
                                begin
                                    acc += longint'(cnn_pkg::weight_value(2, f, c, r, k)) *
                                           fm1[c][iy][ix];
                                end
                            end
                        end
                    end
                    fm2[f][oy][ox] = rescale_activation(acc);
                end
            end
        end
        // Global max per map, lowest index wins a tie
        best_class = 0;
        best_score = 0;
        for (int f = 0; f < NUM_CLASSES; f++) begin
            score = fm2[f][0][0];
            for (int oy = 0; oy < OUT_SIZE_2; oy++) begin
                for (int ox = 0; ox < OUT_SIZE_2; ox++) begin
                    if (fm2[f][oy][ox] > score) begin
                        score = fm2[f][oy][ox];
                    end
                end
            end
            if (f == 0 || score > best_score) begin
                best_class = f;
                best_score = score;
            end
        end
        res.class_id = cnn_pkg::class_t'(best_class);
        res.score = cnn_pkg::pixel_t'(best_score);
        return res;
    endfunction

    function automatic image_t uniform_image(input cnn_pkg::pixel_t value);
        image_t img;
        for (int p = 0; p < IN_SIZE * IN_SIZE; p++) begin
            img[p] = value;
        end
        return img;
    endfunction

    // Pixels roughly within +-1.0 so that results spread over classes
    task automatic make_random_image(output image_t img);
        for (int p = 0; p < IN_SIZE * IN_SIZE; p++) begin
            img[p] = cnn_pkg::pixel_t'($random(seed) % 257);
        end
    endtask

    task automatic check_value(input string name, input cnn_pkg::result_t expected,
                               input cnn_pkg::result_t actual);
        check_count++;
        if (actual !== expected) begin
            fail_count++;
            $display("CHECK FAILED %s: expected class %0d score %0d, actual class %0d score %0d",
                     name, expected.class_id, expected.score, actual.class_id, actual.score);
        end
    endtask

    task automatic push_expected(input cnn_pkg::result_t expected, input string name,
                                 input int due);
        exp_q.push_back(expected);
        name_q.push_back(name);
        due_q.push_back(due);
    endtask

    // Called at a falling edge, result is due after the fourth rising edge
    task automatic drive_image(input image_t img, input string name);
        image = img;
        push_expected(reference_classify(img), name, cycle + LATENCY);
    endtask

    task automatic wait_drain();
        while (due_q.size() > 0) begin
            @(posedge clk);
        end
    endtask

    task automatic begin_test();
        mark_checks = check_count;
        mark_fails = fail_count;
    endtask

    task automatic end_test(input string name);
        int checks;
        int fails;
        checks = check_count - mark_checks;
        fails = fail_count - mark_fails;
        if (fails == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("[%0t] %s done: %0d checks, %0d mismatches", $time, name, checks, fails);
    endtask

    // Compares the front entry once its cycle comes up
    always @(negedge clk) begin
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            check_value(name_q[0], exp_q[0], result);
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        image_t img;
        rst = 1'b0;
        image = '0;

        // Zeros while in reset and for two edges after release
        // Later the l2 bias flushes through, so result is no longer zero
        begin_test();
        for (int c = 1; c <= RESET_CYCLES + 2; c++) begin
            push_expected('0, "reset", c);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        wait_drain();
        end_test("reset");

        // Only the biases act
        begin_test();
        @(negedge clk);
        drive_image(uniform_image('0), "zero_image");
        wait_drain();
        end_test("zero_image");

        // -1.0 everywhere
        begin_test();
        @(negedge clk);
        drive_image(uniform_image(16'shFF00), "all_negative");
        wait_drain();
        end_test("all_negative");

        // Largest positive pixel, sums run past the Q8.8 range
        begin_test();
        @(negedge clk);
        drive_image(uniform_image(16'sh7FFF), "saturating");
        wait_drain();
        end_test("saturating");

        // Back to back, four images in flight
        begin_test();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            @(negedge clk);
            make_random_image(img);
            drive_image(img, $sformatf("random_stream[%0d]", i));
        end
        wait_drain();
        end_test("random_stream");

        $display("Tests passed: %0d, tests failed: %0d, checks: %0d, mismatches: %0d",
                 tests_passed, tests_failed, check_count, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== source/cnn_classifier.sv ====
`timescale 1ns/1ps

module cnn_classifier #(
    parameter int IN_SIZE = 8,
    parameter int FILTERS_1 = 4,
    parameter int NUM_CLASSES = 4,
    parameter int KER_SIZE = 3,
    parameter int STRIDE_1 = 1,
    parameter int STRIDE_2 = 2,
    parameter int PADDING = 1
) (
    input  logic clk,
    input  logic rst,
    input  cnn_pkg::pixel_t [IN_SIZE*IN_SIZE-1:0] image,
    output cnn_pkg::result_t result
);

    localparam int BITS = cnn_pkg::BIT_SIZE;

    // Single-channel input image
    localparam int IN_CHANNELS_1 = 1;

    // Feature map sizes along the chain
    localparam int OUT_SIZE_1 = ((IN_SIZE - KER_SIZE + 2 * PADDING) / STRIDE_1) + 1;
    localparam int OUT_SIZE_2 = ((OUT_SIZE_1 - KER_SIZE + 2 * PADDING) / STRIDE_2) + 1;

    // Weight counts per layer
    localparam int N_WEIGHTS_1 = FILTERS_1 * IN_CHANNELS_1 * KER_SIZE * KER_SIZE;
    localparam int N_WEIGHTS_2 = NUM_CLASSES * FILTERS_1 * KER_SIZE * KER_SIZE;

    // Full-size constant vectors from the package
    localparam cnn_pkg::weight_vec_t WEIGHTS_ALL_1 =
        cnn_pkg::layer_weights(1, FILTERS_1, IN_CHANNELS_1, KER_SIZE);
    localparam cnn_pkg::weight_vec_t WEIGHTS_ALL_2 =
        cnn_pkg::layer_weights(2, NUM_CLASSES, FILTERS_1, KER_SIZE);
    localparam cnn_pkg::bias_vec_t BIASES_ALL_1 = cnn_pkg::layer_biases(1, FILTERS_1);
    localparam cnn_pkg::bias_vec_t BIASES_ALL_2 = cnn_pkg::layer_biases(2, NUM_CLASSES);

    // Trimmed to the exact width each layer expects
    localparam logic [N_WEIGHTS_1*BITS-1:0] WEIGHTS_1 = WEIGHTS_ALL_1[N_WEIGHTS_1*BITS-1:0];
    localparam logic [N_WEIGHTS_2*BITS-1:0] WEIGHTS_2 = WEIGHTS_ALL_2[N_WEIGHTS_2*BITS-1:0];
    localparam logic [FILTERS_1*BITS-1:0] BIASES_1 = BIASES_ALL_1[FILTERS_1*BITS-1:0];
    localparam logic [NUM_CLASSES*BITS-1:0] BIASES_2 = BIASES_ALL_2[NUM_CLASSES*BITS-1:0];

    // Stage outputs, filter-major
    cnn_pkg::pixel_t [FILTERS_1*OUT_SIZE_1*OUT_SIZE_1-1:0] fmap_1;
    cnn_pkg::pixel_t [NUM_CLASSES*OUT_SIZE_2*OUT_SIZE_2-1:0] fmap_2;
    cnn_pkg::pixel_t [NUM_CLASSES-1:0] class_scores;

    // 8x8x1 -> 8x8x4
    conv_layer #(
        .IN_SIZE(IN_SIZE),
        .IN_CHANNELS(IN_CHANNELS_1),
        .FILTERS(FILTERS_1),
        .KER_SIZE(KER_SIZE),
        .STRIDE(STRIDE_1),
        .PADDING(PADDING),
        .LAYER_WEIGHTS(WEIGHTS_1),
        .LAYER_BIASES(BIASES_1)
    ) l1 (
        .clk(clk),
        .rst(rst),
        .fmap_in(image),
        .fmap_out(fmap_1)
    );

    // 8x8x4 -> 4x4xNUM_CLASSES, one map per class
    conv_layer #(
        .IN_SIZE(OUT_SIZE_1),
        .IN_CHANNELS(FILTERS_1),
        .FILTERS(NUM_CLASSES),
        .KER_SIZE(KER_SIZE),
        .STRIDE(STRIDE_2),
        .PADDING(PADDING),
        .LAYER_WEIGHTS(WEIGHTS_2),
        .LAYER_BIASES(BIASES_2)
    ) l2 (
        .clk(clk),
        .rst(rst),
        .fmap_in(fmap_1),
        .fmap_out(fmap_2)
    );

    global_max_pool #(
        .NUM_CLASSES(NUM_CLASSES),
        .ACTIVATIONS_GMP(OUT_SIZE_2 * OUT_SIZE_2)
    ) gmp (
        .clk(clk),
        .rst(rst),
        .fmap_in(fmap_2),
        .class_scores(class_scores)
    );

    class_argmax #(
        .NUM_CLASSES(NUM_CLASSES)
    ) argmax (
        .clk(clk),
        .rst(rst),
        .class_scores(class_scores),
        .result(result)
    );

endmodule

// ==== source/class_argmax.sv ====
`timescale 1ns/1ps

module class_argmax #(
    parameter int NUM_CLASSES = 4
) (
    input  logic clk,
    input  logic rst,
    input  cnn_pkg::pixel_t [NUM_CLASSES-1:0] class_scores,
    output cnn_pkg::result_t result
);

    // Winner before the register
    cnn_pkg::result_t best;

    // Scan in index order
    always_comb begin
        cnn_pkg::pixel_t cand;
        best.class_id = '0;
        best.score = cnn_pkg::pixel_t'(class_scores[0]);
        for (int k = 1; k < NUM_CLASSES; k++) begin
            cand = cnn_pkg::pixel_t'(class_scores[k]);
            // strict compare keeps the lower index on a tie
            if (cand > best.score) begin
                best.class_id = cnn_pkg::class_t'(k);
                best.score = cand;
            end
        end
    end

    // Reset value reads as class 0 with score 0
    always_ff @(posedge clk) begin
        if (!rst) begin
            result <= '0;
        end else begin
            result <= best;
        end
    end

    // Index always names an existing class
    assert property (@(posedge clk) disable iff (!rst)
        int'(result.class_id) < NUM_CLASSES)
        else $error("class_argmax: class index %0d out of range", result.class_id);

endmodule

// ==== source/global_max_pool.sv ====
`timescale 1ns/1ps

module global_max_pool #(
    parameter int NUM_CLASSES = 4,
    parameter int ACTIVATIONS_GMP = 16
) (
    input  logic clk,
    input  logic rst,
    input  cnn_pkg::pixel_t [NUM_CLASSES*ACTIVATIONS_GMP-1:0] fmap_in,
    output cnn_pkg::pixel_t [NUM_CLASSES-1:0] class_scores
);

    // Per-map maxima before the register
    cnn_pkg::pixel_t [NUM_CLASSES-1:0] map_max;

    for (genvar k = 0; k < NUM_CLASSES; k++) begin : g_map

        // Signed maximum over every position of map k
        always_comb begin
            cnn_pkg::pixel_t best;
            cnn_pkg::pixel_t cand;
            best = cnn_pkg::pixel_t'(fmap_in[k*ACTIVATIONS_GMP]);
            for (int p = 1; p < ACTIVATIONS_GMP; p++) begin
                cand = cnn_pkg::pixel_t'(fmap_in[k*ACTIVATIONS_GMP + p]);
                if (cand > best) begin
                    best = cand;
                end
            end
            map_max[k] = best;
        end

        // Score dominates the first position of its map from one cycle before
        assert property (@(posedge clk) disable iff (!rst)
            $past(rst) |->
            cnn_pkg::pixel_t'(class_scores[k]) >=
            cnn_pkg::pixel_t'($past(fmap_in[k*ACTIVATIONS_GMP])))
            else $error("global_max_pool: score %0d below its first activation", k);

    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            class_scores <= '0;
        end else begin
            class_scores <= map_max;
        end
    end

endmodule

// ==== source/conv_layer.sv ====
`timescale 1ns/1ps

module conv_layer #(
    parameter int IN_SIZE = 8,
    parameter int IN_CHANNELS = 1,
    parameter int FILTERS = 4,
    parameter int KER_SIZE = 3,
    parameter int STRIDE = 1,
    parameter int PADDING = 1,
    parameter logic [FILTERS*IN_CHANNELS*KER_SIZE*KER_SIZE*cnn_pkg::BIT_SIZE-1:0]
        LAYER_WEIGHTS = '0,
    parameter logic [FILTERS*cnn_pkg::BIT_SIZE-1:0] LAYER_BIASES = '0
) (
    input  logic clk,
    input  logic rst,
    input  cnn_pkg::pixel_t [IN_SIZE*IN_SIZE*IN_CHANNELS-1:0] fmap_in,
    output cnn_pkg::pixel_t [FILTERS*
        (((IN_SIZE-KER_SIZE+2*PADDING)/STRIDE)+1)**2-1:0] fmap_out
);

    localparam int OUT_SIZE = ((IN_SIZE - KER_SIZE + 2 * PADDING) / STRIDE) + 1;
    localparam int IN_AREA = IN_SIZE * IN_SIZE;
    localparam int OUT_AREA = OUT_SIZE * OUT_SIZE;
    localparam int BITS = cnn_pkg::BIT_SIZE;

    // Largest positive Q8.8 value
    localparam cnn_pkg::acc_t PIXEL_MAX = (cnn_pkg::acc_t'(1) <<< (BITS - 1)) - 1;

    // Next-cycle activations, same layout as fmap_out
    cnn_pkg::pixel_t [FILTERS*OUT_AREA-1:0] act;

    for (genvar f = 0; f < FILTERS; f++) begin : g_filter
        for (genvar oy = 0; oy < OUT_SIZE; oy++) begin : g_row
            for (genvar ox = 0; ox < OUT_SIZE; ox++) begin : g_col

                // Flat position of this activation in the output map
                localparam int OUT_IDX = f * OUT_AREA + oy * OUT_SIZE + ox;

                cnn_pkg::acc_t acc;
                cnn_pkg::acc_t scaled;

                always_comb begin
                    int iy;
                    int ix;
                    int w_idx;
                    cnn_pkg::pixel_t w;
                    cnn_pkg::pixel_t b;
                    b = cnn_pkg::pixel_t'(LAYER_BIASES[f*BITS +: BITS]);
                    // Bias moved up to the Q16.16 product scale
                    acc = cnn_pkg::acc_t'(b) <<< cnn_pkg::FRACTIONAL_BITS;
                    for (int c = 0; c < IN_CHANNELS; c++) begin
                        for (int r = 0; r < KER_SIZE; r++) begin
                            for (int k = 0; k < KER_SIZE; k++) begin
                                iy = STRIDE * oy - PADDING + r;
                                ix = STRIDE * ox - PADDING + k;
                                w_idx = ((f * IN_CHANNELS + c) * KER_SIZE + r) * KER_SIZE + k;
                                w = cnn_pkg::pixel_t'(LAYER_WEIGHTS[w_idx*BITS +: BITS]);
                                // Padding ring contributes nothing
                                if (iy >= 0 && iy < IN_SIZE && ix >= 0 && ix < IN_SIZE) begin
                                    acc = acc + cnn_pkg::acc_t'(w) *
                                        cnn_pkg::acc_t'(fmap_in[c*IN_AREA + iy*IN_SIZE + ix]);
                                end
                            end
                        end
                    end
                end

                // Back to Q8.8, floors toward minus infinity
                assign scaled = acc >>> cnn_pkg::FRACTIONAL_BITS;

                // ReLU, then clip at the top of the Q8.8 range
                always_comb begin
                    if (scaled < 0) begin
                        act[OUT_IDX] = '0;
                    end else if (scaled > PIXEL_MAX) begin
                        act[OUT_IDX] = cnn_pkg::pixel_t'(PIXEL_MAX);
                    end else begin
                        act[OUT_IDX] = scaled[BITS-1:0];
                    end
                end

                // Registered map never holds a negative activation
                assert property (@(posedge clk) disable iff (!rst)
                    !fmap_out[OUT_IDX][BITS-1])
                    else $error("conv_layer: negative activation at %0d", OUT_IDX);

            end
        end
    end

    // One pipeline stage per layer
    always_ff @(posedge clk) begin
        if (!rst) begin
            fmap_out <= '0;
        end else begin
            fmap_out <= act;
        end
    end

endmodule

// ==== source/cnn_pkg.sv ====
package cnn_pkg;

    // Q8.8 fixed point
    localparam int BIT_SIZE = 16;
    localparam int FRACTIONAL_BITS = 8;

    // Room in the flat constant vectors handed to the conv layers
    localparam int MAX_WEIGHTS = 256;
    localparam int MAX_FILTERS = 16;

    // Activation or weight, signed Q8.8
    typedef logic signed [BIT_SIZE-1:0] pixel_t;

    // Q16.16 sum of products, headroom for a full 3x3x4 window plus bias
    typedef logic signed [39:0] acc_t;

    // Up to 16 classes
    typedef logic [3:0] class_t;

    // Flat weight and bias vectors, filter outermost
    typedef logic [MAX_WEIGHTS*BIT_SIZE-1:0] weight_vec_t;
    typedef logic [MAX_FILTERS*BIT_SIZE-1:0] bias_vec_t;

    // Winning class and its score
    typedef struct packed {
        class_t class_id;
        pixel_t score;
    } result_t;

    // Multiple of 0.25 in [-1.0, +1.0]
    function automatic pixel_t weight_value(input int layer, input int filter,
                                            input int channel, input int row,
                                            input int col);
        int step;
        step = (7 * filter + 5 * channel + 3 * row + 2 * col + layer) % 9;
        return pixel_t'((step - 4) * 64);
    endfunction

    // -0.125, 0 or +0.125
    function automatic pixel_t bias_value(input int layer, input int filter);
        int step;
        step = (filter + layer) % 3;
        return pixel_t'((step - 1) * 32);
    endfunction

    // Packs filter, channel, row, column with column fastest
    function automatic weight_vec_t layer_weights(input int layer, input int filters,
                                                  input int in_channels,
                                                  input int ker_size);
        weight_vec_t w;
        int idx;
        w = '0;
        for (int f = 0; f < filters; f++) begin
            for (int c = 0; c < in_channels; c++) begin
                for (int r = 0; r < ker_size; r++) begin
                    for (int k = 0; k < ker_size; k++) begin
                        idx = ((f * in_channels + c) * ker_size + r) * ker_size + k;
                        w[idx*BIT_SIZE +: BIT_SIZE] = weight_value(layer, f, c, r, k);
                    end
                end
            end
        end
        return w;
    endfunction

    // One bias per filter, filter 0 in the lowest bits
    function automatic bias_vec_t layer_biases(input int layer, input int filters);
        bias_vec_t b;
        b = '0;
        for (int f = 0; f < filters; f++) begin
            b[f*BIT_SIZE +: BIT_SIZE] = bias_value(layer, f);
        end
        return b;
    endfunction

endpackage
